// File: hdl/uart_proto_pkg.sv
package uart_proto_pkg;

  localparam int word_len   = 8;             // data bits per frame.
  localparam int cell_ticks = 16;            // oversampling ticks per bit cell.
  localparam int half_cell  = cell_ticks / 2;

  localparam logic start_lvl = 1'b0;
  localparam logic stop_lvl  = 1'b1;         // also the idle level of the line.

  typedef enum logic [2:0] {
    x_idle,
    x_start,
    x_data,
    x_stop
  } xmit_state_t;

  typedef enum logic [2:0] {
    r_idle,
    r_start,
    r_data,
    r_stop
  } recv_state_t;

endpackage

// File: hdl/uart_apb_pkg.sv
package uart_apb_pkg;

  // byte offsets within the register window.
  localparam logic [3:0] addr_txdata   = 4'h0;  // write only.
  localparam logic [3:0] addr_rxdata   = 4'h4;  // read only.
  localparam logic [3:0] addr_status   = 4'h8;
  localparam logic [3:0] addr_baud_div = 4'hC;

  // bit positions in the status word.
  localparam int st_tx_busy    = 0;
  localparam int st_rx_valid   = 1;
  localparam int st_rx_overrun = 2;
  localparam int st_frame_err  = 3;             // write 1 to clear.

  localparam logic [15:0] baud_div_rst = 16'd16;

endpackage

// File: hdl/uart_baud_gen.sv
`timescale 1ns/1ns

module uart_baud_gen #(
  parameter int div_width = 16
) (
  input  logic                 sys_clk,
  input  logic                 sys_rst_l,
  input  logic [div_width-1:0] baud_div,
  output logic                 tick
);

  logic [div_width-1:0] cnt;
  logic [div_width-1:0] reload;

  // a divisor of zero behaves like one.
  assign reload = (baud_div == '0) ? '0 : baud_div - 1'b1;

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      cnt <= '0;
    end else if (cnt == '0) begin
      cnt <= reload;
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

  assign tick = (cnt == '0);

endmodule

// File: hdl/uart_xmit.sv
`timescale 1ns/1ns

module uart_xmit import uart_proto_pkg::*; (
  input  logic       sys_clk,
  input  logic       sys_rst_l,
  input  logic       tick,
  input  logic       xmit,
  input  logic [7:0] xmit_data,
  output logic       txd,
  output logic       xmit_done
);

  localparam logic [3:0] cell_last = 4'(cell_ticks - 1);
  localparam logic [3:0] bit_last  = 4'(word_len - 1);

  xmit_state_t state;
  logic [3:0]  cell_cnt;
  logic [3:0]  bit_cnt;
  logic [7:0]  shift_reg;
  logic        cell_end;
  logic        shift_en;
  logic        line_lvl;

  assign cell_end = tick && (cell_cnt == cell_last);
  assign shift_en = (state == x_data) && cell_end;

  // line select.
  always_comb begin
    case (state)
      x_start: line_lvl = start_lvl;
      x_data:  line_lvl = shift_reg[0];
      default: line_lvl = stop_lvl;
    endcase
  end

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      state     <= x_idle;
      cell_cnt  <= '0;
      bit_cnt   <= '0;
      xmit_done <= 1'b1;
      txd       <= stop_lvl;
    end else begin
      txd <= line_lvl;
      case (state)
        x_idle: begin
          if (xmit) begin
            xmit_done <= 1'b0;
          end else if (!xmit_done && tick) begin  // frame starts on the first tick.
            state    <= x_start;
            cell_cnt <= '0;
          end
        end
        x_start: begin
          if (cell_end) begin
            state    <= x_data;
            cell_cnt <= '0;
            bit_cnt  <= '0;
          end else if (tick) begin
            cell_cnt <= cell_cnt + 1'b1;
          end
        end
        x_data: begin
          if (cell_end) begin
            cell_cnt <= '0;
            if (bit_cnt == bit_last) begin
              state <= x_stop;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end else if (tick) begin
            cell_cnt <= cell_cnt + 1'b1;
          end
        end
        x_stop: begin
          if (cell_end) begin
            state     <= x_idle;
            xmit_done <= 1'b1;
          end else if (tick) begin
            cell_cnt <= cell_cnt + 1'b1;
          end
        end
        default: state <= x_idle;
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (state == x_idle && xmit) begin
      shift_reg <= xmit_data;
    end else if (shift_en) begin
      shift_reg <= {stop_lvl, shift_reg[7:1]};  // lsb goes out first.
    end
  end

endmodule

// File: hdl/uart_recv.sv
`timescale 1ns/1ns

module uart_recv import uart_proto_pkg::*; (
  input  logic       sys_clk,
  input  logic       sys_rst_l,
  input  logic       tick,
  input  logic       rxd,
  output logic       recv_valid,
  output logic [7:0] recv_data,
  output logic       frame_err
);

  localparam logic [3:0] cell_last = 4'(cell_ticks - 1);
  localparam logic [3:0] half_last = 4'(half_cell - 1);
  localparam logic [3:0] bit_last  = 4'(word_len - 1);

  recv_state_t state;
  logic        rxd_meta;
  logic        rxd_sync;
  logic [3:0]  cell_cnt;
  logic [3:0]  bit_cnt;
  logic        cell_end;
  logic        shift_en;

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      rxd_meta <= stop_lvl;
      rxd_sync <= stop_lvl;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
    end
  end

  assign cell_end = tick && (cell_cnt == cell_last);
  assign shift_en = (state == r_data) && cell_end;

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      state      <= r_idle;
      cell_cnt   <= '0;
      bit_cnt    <= '0;
      recv_valid <= 1'b0;
      frame_err  <= 1'b0;
    end else begin
      recv_valid <= 1'b0;
      case (state)
        r_idle: begin
          if (tick && rxd_sync == start_lvl) begin
            state    <= r_start;
            cell_cnt <= '0;
          end
        end
        r_start: begin
          if (tick && cell_cnt == half_last) begin  // middle of the start cell.
            cell_cnt <= '0;
            bit_cnt  <= '0;
            state    <= (rxd_sync == start_lvl) ? r_data : r_idle;
          end else if (tick) begin
            cell_cnt <= cell_cnt + 1'b1;
          end
        end
        r_data: begin
          if (cell_end) begin
            cell_cnt <= '0;
            if (bit_cnt == bit_last) begin
              state <= r_stop;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end else if (tick) begin
            cell_cnt <= cell_cnt + 1'b1;
          end
        end
        r_stop: begin
          if (cell_end) begin
            state      <= r_idle;
            recv_valid <= 1'b1;
            frame_err  <= (rxd_sync != stop_lvl);
          end else if (tick) begin
            cell_cnt <= cell_cnt + 1'b1;
          end
        end
        default: state <= r_idle;
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (shift_en) begin
      recv_data <= {rxd_sync, recv_data[7:1]};  // lsb arrives first.
    end
  end

endmodule

// File: hdl/uart_apb_regs.sv
`timescale 1ns/1ns

module uart_apb_regs import uart_apb_pkg::*; #(
  parameter int div_width = 16
) (
  input  logic                 sys_clk,
  input  logic                 sys_rst_l,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [3:0]           paddr,
  input  logic [31:0]          pwdata,
  output logic [31:0]          prdata,
  output logic                 pslverr,
  input  logic                 xmit_done,
  output logic                 xmit,
  output logic [7:0]           xmit_data,
  input  logic                 recv_valid,
  input  logic [7:0]           recv_data,
  input  logic                 frame_err,
  output logic [div_width-1:0] baud_div
);

  logic        access;
  logic        wr;
  logic        rd_rx;
  logic        mapped;
  logic        tx_busy;
  logic        tx_accept;
  logic [7:0]  rx_byte;
  logic        rx_valid;
  logic        rx_overrun;
  logic        frame_err_q;
  logic [31:0] status;

  assign access = psel && penable;
  assign wr     = access && pwrite;
  assign rd_rx  = access && !pwrite && (paddr == addr_rxdata);
  assign mapped = (paddr == addr_txdata) || (paddr == addr_rxdata) ||
                  (paddr == addr_status) || (paddr == addr_baud_div);

  assign tx_busy   = !xmit_done || xmit;  // busy from the strobe on.
  assign tx_accept = wr && (paddr == addr_txdata) && !tx_busy;
  assign pslverr   = access && (!mapped || (pwrite && paddr == addr_txdata && tx_busy));

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      xmit        <= 1'b0;
      rx_valid    <= 1'b0;
      rx_overrun  <= 1'b0;
      frame_err_q <= 1'b0;
      baud_div    <= div_width'(baud_div_rst);
    end else begin
      xmit <= tx_accept;
      if (wr && paddr == addr_baud_div) begin
        baud_div <= pwdata[div_width-1:0];
      end
      if (rd_rx) begin
        rx_valid   <= 1'b0;
        rx_overrun <= 1'b0;
      end
      if (recv_valid) begin
        if (rx_valid && !rd_rx) begin
          rx_overrun <= 1'b1;  // old byte is kept.
        end else begin
          rx_valid <= 1'b1;
        end
      end
      if (recv_valid && frame_err) begin
        frame_err_q <= 1'b1;
      end else if (wr && paddr == addr_status && pwdata[st_frame_err]) begin
        frame_err_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (tx_accept) begin
      xmit_data <= pwdata[7:0];
    end
    if (recv_valid && !(rx_valid && !rd_rx)) begin
      rx_byte <= recv_data;
    end
  end

  always_comb begin
    status                = '0;
    status[st_tx_busy]    = tx_busy;
    status[st_rx_valid]   = rx_valid;
    status[st_rx_overrun] = rx_overrun;
    status[st_frame_err]  = frame_err_q;
  end

  always_comb begin
    case (paddr)
      addr_rxdata:   prdata = {24'h0, rx_byte};
      addr_status:   prdata = status;
      addr_baud_div: prdata = 32'(baud_div);
      default:       prdata = '0;  // txdata reads back as zero.
    endcase
  end

endmodule

// File: hdl/uart_apb_top.sv
`timescale 1ns/1ns

module uart_apb_top #(
  parameter int div_width = 16
) (
  input  logic        sys_clk,
  input  logic        sys_rst_l,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        txd,
  input  logic        rxd
);

  logic [div_width-1:0] baud_div;
  logic                 tick;
  logic                 xmit;
  logic [7:0]           xmit_data;
  logic                 xmit_done;
  logic                 recv_valid;
  logic [7:0]           recv_data;
  logic                 frame_err;

  assign pready = 1'b1;  // no wait states.

  uart_apb_regs #(
    .div_width (div_width)
  ) uart_apb_regs_inst (
    .sys_clk    (sys_clk),
    .sys_rst_l  (sys_rst_l),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pslverr    (pslverr),
    .xmit_done  (xmit_done),
    .xmit       (xmit),
    .xmit_data  (xmit_data),
    .recv_valid (recv_valid),
    .recv_data  (recv_data),
    .frame_err  (frame_err),
    .baud_div   (baud_div)
  );

  uart_baud_gen #(
    .div_width (div_width)
  ) uart_baud_gen_inst (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l),
    .baud_div  (baud_div),
    .tick      (tick)
  );

  uart_xmit uart_xmit_inst (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l),
    .tick      (tick),
    .xmit      (xmit),
    .xmit_data (xmit_data),
    .txd       (txd),
    .xmit_done (xmit_done)
  );

  uart_recv uart_recv_inst (
    .sys_clk    (sys_clk),
    .sys_rst_l  (sys_rst_l),
    .tick       (tick),
    .rxd        (rxd),
    .recv_valid (recv_valid),
    .recv_data  (recv_data),
    .frame_err  (frame_err)
  );

endmodule

// File: test/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int half_period = 5,
  parameter int rst_cycles  = 4
) (
  output logic sys_clk,
  output logic sys_rst_l
);

  initial begin
    sys_clk = 1'b0;
    forever #half_period sys_clk = ~sys_clk;
  end

  initial begin
    sys_rst_l = 1'b0;
    repeat (rst_cycles) @(posedge sys_clk);
    sys_rst_l <= 1'b1;  // released on a rising edge.
  end

endmodule

// File: test/tb_uart_apb_top.sv
`timescale 1ns/1ns

module tb_uart_apb_top import uart_proto_pkg::*, uart_apb_pkg::*; ();

  localparam int test_div   = 4;                        // baud divisor used by the tests.
  localparam int cell_clks  = cell_ticks * test_div;
  localparam int frame_clks = (word_len + 2) * cell_clks;
  localparam int n_frames   = 16;                       // frames sent over all tests.
  localparam int timeout_ns = (n_frames + 8) * frame_clks * 10;

  logic        sys_clk;
  logic        sys_rst_l;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        txd;
  logic        rxd;
  logic        loopback;
  logic        ser_line;

  string       cur_test;
  int          n_checks;
  int          n_errors;
  int          n_tests;
  int          n_failed;
  int          test_err_start;
  int          rnd_seed;

  assign rxd = loopback ? txd : ser_line;

  tb_clk_gen tb_clk_gen_inst (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l)
  );

  uart_apb_top #(
    .div_width (16)
  ) uart_apb_top_inst (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .txd       (txd),
    .rxd       (rxd)
  );

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    n_checks++;
    assert (actual === expected) else begin
      $display("[ERROR] %s %s: expected 0x%0h, actual 0x%0h", cur_test, what, expected, actual);
      n_errors++;
    end
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
    @(posedge sys_clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge sys_clk);
    penable <= 1'b1;
    @(negedge sys_clk);
    err = pslverr;  // access phase.
    check_value("write pready", 32'd1, {31'd0, pready});
    @(posedge sys_clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
    @(posedge sys_clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge sys_clk);
    penable <= 1'b1;
    @(negedge sys_clk);
    data = prdata;
    err  = pslverr;
    check_value("read pready", 32'd1, {31'd0, pready});
    @(posedge sys_clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic wait_tx_idle();
    logic [31:0] rd;
    logic        err;
    do begin
      apb_read(addr_status, rd, err);
    end while (rd[st_tx_busy]);
  endtask

  task automatic wait_status_set(input int idx);
    logic [31:0] rd;
    logic        err;
    do begin
      apb_read(addr_status, rd, err);
    end while (!rd[idx]);
  endtask

  task automatic send_byte(input logic [7:0] data);
    logic err;
    wait_tx_idle();
    apb_write(addr_txdata, {24'h0, data}, err);
    check_value("txdata pslverr", 32'd0, {31'd0, err});
  endtask

  // samples txd mid-cell, counted from the falling start edge.
  task automatic watch_tx_frame(input logic [7:0] data);
    logic [9:0] exp_bits;
    exp_bits = {1'b1, data, 1'b0};
    @(negedge sys_clk);
    while (txd !== 1'b0) @(negedge sys_clk);
    repeat (cell_clks / 2) @(negedge sys_clk);
    for (int i = 0; i < word_len + 2; i++) begin
      check_value($sformatf("txd cell %0d", i), {31'd0, exp_bits[i]}, {31'd0, txd});
      if (i < word_len + 1) begin
        repeat (cell_clks) @(negedge sys_clk);
      end
    end
  endtask

  task automatic drive_frame(input logic [7:0] data, input logic stop_bit);
    logic [9:0] bits;
    bits = {stop_bit, data, 1'b0};
    for (int i = 0; i < word_len + 2; i++) begin
      @(posedge sys_clk);
      ser_line <= bits[i];
      repeat (cell_clks - 1) @(posedge sys_clk);
    end
    @(posedge sys_clk);
    ser_line <= 1'b1;  // back to idle.
  endtask

  task automatic start_test(input string name);
    cur_test       = name;
    test_err_start = n_errors;
  endtask

  task automatic finish_test();
    int errs;
    errs = n_errors - test_err_start;
    n_tests++;
    if (errs != 0) begin
      n_failed++;
    end
    $display("test %-14s %s (%0d errors)", cur_test, (errs != 0) ? "failed" : "passed", errs);
  endtask

  task automatic test_reset_state();
    logic [31:0] rd;
    logic        err;
    start_test("reset_state");
    apb_read(addr_status, rd, err);
    check_value("status", 32'd0, rd);
    check_value("status pslverr", 32'd0, {31'd0, err});
    apb_read(addr_baud_div, rd, err);
    check_value("baud_div", {16'd0, baud_div_rst}, rd);
    @(negedge sys_clk);
    check_value("txd idle", 32'd1, {31'd0, txd});
    finish_test();
  endtask

  task automatic test_tx_framing();
    logic [7:0] data;
    logic       err;
    start_test("tx_framing");
    data = 8'($urandom);
    apb_write(addr_baud_div, test_div, err);
    check_value("baud_div pslverr", 32'd0, {31'd0, err});
    send_byte(data);
    watch_tx_frame(data);
    wait_tx_idle();
    finish_test();
  endtask

  task automatic test_busy_reject();
    logic [31:0] rd;
    logic        err;
    start_test("busy_reject");
    send_byte(8'($urandom));
    apb_write(addr_txdata, 32'h5a, err);
    check_value("busy write pslverr", 32'd1, {31'd0, err});
    apb_read(addr_status, rd, err);
    check_value("tx_busy", 32'd1, {31'd0, rd[st_tx_busy]});
    send_byte(8'($urandom));
    apb_write(4'h2, 32'h0, err);
    check_value("unmapped write pslverr", 32'd1, {31'd0, err});
    apb_read(4'h6, rd, err);
    check_value("unmapped read pslverr", 32'd1, {31'd0, err});
    wait_tx_idle();
    finish_test();
  endtask

  task automatic test_loopback();
    logic [7:0]  data;
    logic [31:0] rd;
    logic        err;
    start_test("loopback");
    loopback <= 1'b1;
    for (int i = 0; i < 10; i++) begin
      data = 8'($urandom);
      send_byte(data);
      wait_status_set(st_rx_valid);
      apb_read(addr_rxdata, rd, err);
      check_value("rxdata", {24'd0, data}, rd);
      apb_read(addr_status, rd, err);
      check_value("rx_valid after read", 32'd0, {31'd0, rd[st_rx_valid]});
    end
    finish_test();
  endtask

  task automatic test_overrun();
    logic [7:0]  first;
    logic [31:0] rd;
    logic        err;
    start_test("overrun");
    first = 8'($urandom);
    send_byte(first);
    wait_status_set(st_rx_valid);
    send_byte(~first);  // differs from the kept byte in every bit.
    wait_status_set(st_rx_overrun);
    apb_read(addr_rxdata, rd, err);
    check_value("rxdata kept", {24'd0, first}, rd);
    apb_read(addr_status, rd, err);
    check_value("flags after read", 32'd0, {30'd0, rd[st_rx_overrun], rd[st_rx_valid]});
    wait_tx_idle();
    finish_test();
  endtask

  task automatic test_frame_err();
    logic [7:0]  data;
    logic [31:0] rd;
    logic        err;
    start_test("frame_err");
    data = 8'($urandom);
    loopback <= 1'b0;
    drive_frame(data, 1'b0);
    wait_status_set(st_rx_valid);
    apb_read(addr_status, rd, err);
    check_value("frame_err set", 32'd1, {31'd0, rd[st_frame_err]});
    apb_read(addr_rxdata, rd, err);
    check_value("rxdata", {24'd0, data}, rd);
    apb_read(addr_status, rd, err);
    check_value("frame_err sticky", 32'd1, {31'd0, rd[st_frame_err]});
    apb_write(addr_status, 32'd1 << st_frame_err, err);
    apb_read(addr_status, rd, err);
    check_value("frame_err cleared", 32'd0, {31'd0, rd[st_frame_err]});
    finish_test();
  endtask

  initial begin
    #(timeout_ns);
    $display("timeout: the tests did not finish within %0d ns", timeout_ns);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    psel     <= 1'b0;
    penable  <= 1'b0;
    pwrite   <= 1'b0;
    paddr    <= '0;
    pwdata   <= '0;
    loopback <= 1'b0;
    ser_line <= 1'b1;
    n_checks = 0;
    n_errors = 0;
    n_tests  = 0;
    n_failed = 0;
    rnd_seed = $urandom(49341);
    @(posedge sys_clk);
    wait (sys_rst_l === 1'b1);
    test_reset_state();
    test_tx_framing();
    test_busy_reject();
    test_loopback();
    test_overrun();
    test_frame_err();
    $display("tests: %0d, failed tests: %0d, checks: %0d, errors: %0d",
             n_tests, n_failed, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: uart_apb.f
hdl/uart_proto_pkg.sv
hdl/uart_apb_pkg.sv
hdl/uart_baud_gen.sv
hdl/uart_xmit.sv
hdl/uart_recv.sv
hdl/uart_apb_regs.sv
hdl/uart_apb_top.sv
test/tb_clk_gen.sv
test/tb_uart_apb_top.sv

// File: Bender.yml
package:
  name: uart_apb

sources:
  - hdl/uart_proto_pkg.sv
  - hdl/uart_apb_pkg.sv
  - hdl/uart_baud_gen.sv
  - hdl/uart_xmit.sv
  - hdl/uart_recv.sv
  - hdl/uart_apb_regs.sv
  - hdl/uart_apb_top.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_uart_apb_top.sv
